/* hdl/spi_clk_gen.sv */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_clk_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic run,
	output logic sck_phase,
	output logic rise_stb,
	output logic fall_stb
);

	localparam int CNT_W = (`SPI_DIV > 1) ? $clog2(`SPI_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPI_DIV - 1);

	logic [CNT_W-1:0] half_cnt;
	logic             half_end;

	// Last cycle of the current half period
	assign half_end = run && (half_cnt == CNT_LAST);

	// Strobes mark the cycle whose closing edge toggles the phase
	assign rise_stb = half_end && !sck_phase;
	assign fall_stb = half_end && sck_phase;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			half_cnt  <= '0;
			sck_phase <= 1'b0;
		end else if (!run) begin
			// Held at zero so every transfer starts in the same phase
			half_cnt  <= '0;
			sck_phase <= 1'b0;
		end else if (half_end) begin
			half_cnt  <= '0;
			sck_phase <= !sck_phase;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Falling strobe comes one half period after the rising one
	a_strobe_spacing: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		fall_stb |-> $past(rise_stb, `SPI_DIV)
	);

endmodule

/* hdl/spi_cmd_seq.sv */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_cmd_seq (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic                  cmd_valid,
	input  spi_pkg::spi_op_t      cmd_op,
	input  logic [`SPI_WIDTH-1:0] cmd_data,
	input  logic [`SPI_WIDTH-1:0] cmd_mask,
	output logic                  busy,
	output logic                  rsp_valid,
	output logic [`SPI_WIDTH-1:0] rsp_data,
	output logic                  rsp_timeout,
	output logic                  spi_sck,
	output logic                  spi_cs,
	output logic                  spi_mosi,
	input  logic                  spi_miso
);

	import spi_pkg::*;

	localparam int POLL_W = $clog2(`SPI_POLL_LIMIT + 1);
	localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(`SPI_POLL_LIMIT);

	spi_op_t               op_q;
	logic [`SPI_WIDTH-1:0] data_q;
	logic [`SPI_WIDTH-1:0] mask_q;
	logic [POLL_W-1:0]     poll_cnt;
	logic                  xfer_start;
	logic                  xfer_done;
	logic [`SPI_WIDTH-1:0] rx_data;
	logic                  masked_hit;

	// Status bits still set under the mask
	assign masked_hit = |(rx_data & mask_q);

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			busy        <= 1'b0;
			rsp_valid   <= 1'b0;
			rsp_timeout <= 1'b0;
			xfer_start  <= 1'b0;
			op_q        <= OP_XFER;
			poll_cnt    <= '0;
		end else begin
			rsp_valid  <= 1'b0;
			xfer_start <= 1'b0;
			if (cmd_valid && !busy) begin
				// Commands seen while busy are dropped
				busy       <= 1'b1;
				xfer_start <= 1'b1;
				op_q       <= cmd_op;
				poll_cnt   <= POLL_W'(1);
			end else if (busy && xfer_done) begin
				if (op_q == OP_POLL && masked_hit && poll_cnt != POLL_LAST) begin
					xfer_start <= 1'b1;
					poll_cnt   <= poll_cnt + 1'b1;
				end else begin
					busy        <= 1'b0;
					rsp_valid   <= 1'b1;
					rsp_timeout <= (op_q == OP_POLL) && masked_hit;
				end
			end
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (cmd_valid && !busy) begin
			data_q <= cmd_data;
			mask_q <= cmd_mask;
		end
	end

	// Shifter holds the word until the next start
	assign rsp_data = rx_data;

	spi_shifter u_shifter (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.xfer_start (xfer_start),
		.tx_data    (data_q),
		.xfer_done  (xfer_done),
		.rx_data    (rx_data),
		.spi_sck    (spi_sck),
		.spi_cs     (spi_cs),
		.spi_mosi   (spi_mosi),
		.spi_miso   (spi_miso)
	);

	a_rsp_after_busy: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid |-> $past(busy)
	);

endmodule

/* hdl/spi_master_top.sv */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_master_top (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	// Host side
	input  logic                  cmd_valid,
	input  spi_pkg::spi_op_t      cmd_op,
	input  logic [`SPI_WIDTH-1:0] cmd_data,
	input  logic [`SPI_WIDTH-1:0] cmd_mask,
	output logic                  busy,
	output logic                  rsp_valid,
	output logic [`SPI_WIDTH-1:0] rsp_data,
	output logic                  rsp_timeout,
	// SPI pins
	output logic                  spi_sck,
	output logic                  spi_cs,
	output logic                  spi_mosi,
	input  logic                  spi_miso
);

	spi_cmd_seq u_cmd_seq (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.cmd_valid   (cmd_valid),
		.cmd_op      (cmd_op),
		.cmd_data    (cmd_data),
		.cmd_mask    (cmd_mask),
		.busy        (busy),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data),
		.rsp_timeout (rsp_timeout),
		.spi_sck     (spi_sck),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso)
	);

endmodule

/* hdl/spi_pkg.sv */
package spi_pkg;

	////////////////////////////////////////////////////////////////////////
	// Transfer engine states
	////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} spi_state_t;

	////////////////////////////////////////////////////////////////////////
	// Host command opcodes
	////////////////////////////////////////////////////////////////////////
	typedef enum logic {
		OP_XFER,
		OP_POLL
	} spi_op_t;

endpackage

/* hdl/spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Bits per SPI transfer and width of the data and mask words
`define SPI_WIDTH 32

// System cycles per SCK half period (minimum 1)
`define SPI_DIV 2

// Most transfers a single POLL command may run
`define SPI_POLL_LIMIT 8

`endif

/* hdl/spi_shifter.sv */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_shifter (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic                  xfer_start,
	input  logic [`SPI_WIDTH-1:0] tx_data,
	output logic                  xfer_done,
	output logic [`SPI_WIDTH-1:0] rx_data,
	output logic                  spi_sck,
	output logic                  spi_cs,
	output logic                  spi_mosi,
	input  logic                  spi_miso
);

	import spi_pkg::*;

	localparam int CNT_W = $clog2(`SPI_WIDTH + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPI_WIDTH);

	spi_state_t            state;
	logic [CNT_W-1:0]      bit_cnt;
	logic [`SPI_WIDTH-1:0] shift_reg;
	logic                  miso_q;
	logic                  run;
	logic                  sck_phase;
	logic                  rise_stb;
	logic                  fall_stb;

	assign run = (state == SHIFT);

	spi_clk_gen u_clk_gen (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.run       (run),
		.sck_phase (sck_phase),
		.rise_stb  (rise_stb),
		.fall_stb  (fall_stb)
	);

	////////////////////////////////////////////////////////////////////////
	// Transfer control
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state     <= IDLE;
			spi_cs    <= 1'b1;
			bit_cnt   <= '0;
			xfer_done <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			case (state)
				IDLE: begin
					if (xfer_start) begin
						state   <= SHIFT;
						spi_cs  <= 1'b0;
						bit_cnt <= '0;
					end
				end
				SHIFT: begin
					// Count SCK pulses by their rising edge
					if (rise_stb)
						bit_cnt <= bit_cnt + 1'b1;
					// Falling edge after the last pulse ends the frame
					if (fall_stb && bit_cnt == CNT_LAST) begin
						state  <= DONE;
						spi_cs <= 1'b1;
					end
				end
				DONE: begin
					state     <= IDLE;
					xfer_done <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (state == IDLE && xfer_start)
			shift_reg <= tx_data;
		else if (state == SHIFT && fall_stb)
			shift_reg <= {shift_reg[`SPI_WIDTH-2:0], miso_q};
		// MISO sampled on the rising edge, shifted in on the falling one
		if (state == SHIFT && rise_stb)
			miso_q <= spi_miso;
	end

	// Received word fills the register once the last bit is shifted in
	assign rx_data  = shift_reg;
	assign spi_sck  = sck_phase && !spi_cs;
	assign spi_mosi = shift_reg[`SPI_WIDTH-1] && !spi_cs;

	a_cs_low_in_shift: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		(state == SHIFT) |-> !spi_cs
	);

	a_done_one_cycle: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		xfer_done |=> !xfer_done
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_spi_master -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation run exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

/* src.f */
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_clk_gen.sv
hdl/spi_shifter.sv
hdl/spi_cmd_seq.sv
hdl/spi_master_top.sv
verification/tb_clk_gen.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

/* verification/spi_slave_model.sv */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_slave_model (
	input  logic                  spi_sck,
	input  logic                  spi_cs,
	input  logic                  spi_mosi,
	output logic                  spi_miso,
	input  logic [`SPI_WIDTH-1:0] expect_word,
	output int                    cs_falls,
	output int                    rx_errors
);

	logic [`SPI_WIDTH-1:0] tx_reg    = '0;
	logic [`SPI_WIDTH-1:0] rx_reg    = '0;
	logic [`SPI_WIDTH-1:0] echo_word = '0;
	logic                  cs_prev   = 1'b1;
	logic                  sck_prev  = 1'b0;

	initial begin
		cs_falls  = 0;
		rx_errors = 0;
	end

	assign spi_miso = tx_reg[`SPI_WIDTH-1];

	// Mode 0 samples MOSI on rising SCK and changes MISO on falling SCK
	always @(spi_cs or spi_sck) begin
		if (!spi_cs && cs_prev) begin
			tx_reg   = echo_word;
			cs_falls = cs_falls + 1;
		end else if (spi_cs && !cs_prev) begin
			if (rx_reg !== expect_word) begin
				$display("MISMATCH at %0t: slave received %h, expected %h",
					$time, rx_reg, expect_word);
				rx_errors = rx_errors + 1;
			end
			// Echoed back one transaction late
			echo_word = rx_reg;
		end else if (!spi_cs && spi_sck && !sck_prev) begin
			rx_reg = {rx_reg[`SPI_WIDTH-2:0], spi_mosi};
		end else if (!spi_cs && !spi_sck && sck_prev) begin
			tx_reg = {tx_reg[`SPI_WIDTH-2:0], 1'b0};
		end
		cs_prev  = spi_cs;
		sck_prev = spi_sck;
	end

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
	output logic CLK50MHZ,
	output logic RST
);

	// 20 ns period
	initial CLK50MHZ = 1'b0;
	always #10 CLK50MHZ = !CLK50MHZ;

	initial begin
		RST = 1'b1;
		repeat (16) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RST = 1'b0;
	end

endmodule

/* verification/tb_spi_master.sv */
`timescale 1ns/1ns
`include "spi_settings.svh"

module tb_spi_master;

	import spi_pkg::*;

	localparam int WAIT_LIMIT = `SPI_POLL_LIMIT * (2 * `SPI_WIDTH * `SPI_DIV + 10) + 50;

	logic                  CLK50MHZ;
	logic                  RST;
	logic                  cmd_valid;
	spi_op_t               cmd_op;
	logic [`SPI_WIDTH-1:0] cmd_data;
	logic [`SPI_WIDTH-1:0] cmd_mask;
	logic                  busy;
	logic                  rsp_valid;
	logic [`SPI_WIDTH-1:0] rsp_data;
	logic                  rsp_timeout;
	logic                  spi_sck;
	logic                  spi_cs;
	logic                  spi_mosi;
	logic                  spi_miso;

	logic [`SPI_WIDTH-1:0] expect_word;
	logic [`SPI_WIDTH-1:0] prev_word;
	logic [`SPI_WIDTH-1:0] exp_data;
	logic                  exp_timeout;
	int                    exp_xfers;
	int                    cs_base;
	int                    cs_falls;
	int                    rx_errors;
	int                    assert_errs;
	int                    timeout_errs;
	int                    sck_cnt;
	logic                  sck_q;
	logic                  cmd_seen;
	logic                  rsp_seen;
	logic [31:0]           lfsr;

	tb_clk_gen u_clk (.CLK50MHZ(CLK50MHZ), .RST(RST));

	spi_master_top dut (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data), .cmd_mask(cmd_mask),
		.busy(busy), .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_timeout(rsp_timeout),
		.spi_sck(spi_sck), .spi_cs(spi_cs), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

	spi_slave_model u_slave (
		.spi_sck(spi_sck), .spi_cs(spi_cs), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
		.expect_word(expect_word), .cs_falls(cs_falls), .rx_errors(rx_errors)
	);

	//////////////////////////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////////////////////////
	always @(posedge CLK50MHZ) begin
		sck_q <= spi_sck;
		if (spi_cs)
			sck_cnt <= 0;
		else if (spi_sck && !sck_q)
			sck_cnt <= sck_cnt + 1;
		if (RST) begin
			cmd_seen <= 1'b0;
			rsp_seen <= 1'b0;
		end else if (cmd_valid && !busy) begin
			cmd_seen <= 1'b1;
			rsp_seen <= 1'b0;
		end else if (rsp_valid) begin
			rsp_seen <= 1'b1;
		end
	end

	a_reset_idle: assert property (@(posedge CLK50MHZ) disable iff (RST)
		!cmd_seen |-> (spi_cs && !spi_sck && !busy && !rsp_valid))
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: pins or status not idle before first command", $time);
		end

	a_sck_idle: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_cs |-> !spi_sck)
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: SCK high while CS is high", $time);
		end

	a_sck_pulses: assert property (@(posedge CLK50MHZ) disable iff (RST)
		$rose(spi_cs) |-> (sck_cnt == `SPI_WIDTH))
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: %0d SCK pulses in frame", $time, sck_cnt);
		end

	a_busy_rise: assert property (@(posedge CLK50MHZ) disable iff (RST)
		(cmd_valid && !busy) |=> busy)
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: busy did not rise after command", $time);
		end

	a_rsp_data: assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid |-> (rsp_data == exp_data && !busy))
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: rsp_data %h expected %h busy %b",
				$time, rsp_data, exp_data, busy);
		end

	a_rsp_timeout: assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid |-> (rsp_timeout == exp_timeout))
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: rsp_timeout %b expected %b",
				$time, rsp_timeout, exp_timeout);
		end

	a_xfer_count: assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid |-> (cs_falls - cs_base == exp_xfers))
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: %0d transfers, expected %0d",
				$time, cs_falls - cs_base, exp_xfers);
		end

	a_single_rsp: assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid |-> !rsp_seen)
		else begin
			assert_errs++;
			$display("MISMATCH at %0t: second response for one command", $time);
		end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic next_word(output logic [`SPI_WIDTH-1:0] w);
		w = '0;
		for (int i = 0; i < `SPI_WIDTH; i++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[`SPI_WIDTH-2:0], lfsr[0]};
		end
	endtask

	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (busy !== level && n < WAIT_LIMIT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if (busy !== level) begin
			timeout_errs++;
			$display("Timed out at %0t waiting for busy during %s", $time, what);
		end
	endtask

	task automatic wait_rsp(input string what);
		int n;
		n = 0;
		while (rsp_valid !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if (rsp_valid !== 1'b1) begin
			timeout_errs++;
			$display("Timed out at %0t waiting for a response to %s", $time, what);
		end
	endtask

	// Expected result from the echo rule and the poll rule
	task automatic send_cmd(input spi_op_t op, input logic [`SPI_WIDTH-1:0] data,
		input logic [`SPI_WIDTH-1:0] mask);
		logic [`SPI_WIDTH-1:0] rx;
		int n;
		rx = prev_word;
		n = 1;
		if (op == OP_POLL) begin
			while ((rx & mask) != '0 && n < `SPI_POLL_LIMIT) begin
				n++;
				rx = data;
			end
		end
		exp_data    = rx;
		exp_xfers   = n;
		exp_timeout = (op == OP_POLL) && ((rx & mask) != '0);
		expect_word = data;
		prev_word   = data;
		cs_base     = cs_falls;
		@(negedge CLK50MHZ);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_data  = data;
		cmd_mask  = mask;
		@(negedge CLK50MHZ);
		cmd_valid = 1'b0;
	endtask

	task automatic run_cmd(input spi_op_t op, input logic [`SPI_WIDTH-1:0] data,
		input logic [`SPI_WIDTH-1:0] mask, input string what);
		wait_busy(1'b0, what);
		send_cmd(op, data, mask);
		wait_rsp(what);
		@(negedge CLK50MHZ);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [`SPI_WIDTH-1:0] w;
		logic [`SPI_WIDTH-1:0] junk;
		int n;
		cmd_valid    = 1'b0;
		cmd_op       = OP_XFER;
		cmd_data     = '0;
		cmd_mask     = '0;
		expect_word  = '0;
		prev_word    = '0;
		exp_data     = '0;
		exp_timeout  = 1'b0;
		exp_xfers    = 0;
		cs_base      = 0;
		assert_errs  = 0;
		timeout_errs = 0;
		lfsr         = 32'h6526_51a3;

		// Wait for reset release
		@(negedge CLK50MHZ);
		n = 0;
		while (RST !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if (RST !== 1'b0) begin
			timeout_errs++;
			$display("Timed out at %0t waiting for reset release", $time);
		end
		repeat (10) @(negedge CLK50MHZ);

		for (int i = 0; i < 3; i++) begin
			next_word(w);
			run_cmd(OP_XFER, w, '0, "XFER");
		end

		// Mask disjoint from the echoed word
		next_word(w);
		run_cmd(OP_POLL, w, ~prev_word, "short POLL");

		// Mask covers every bit and the limit is reached
		next_word(w);
		run_cmd(OP_POLL, w | 1'b1, '1, "long POLL");

		// Second command lands while busy
		next_word(w);
		next_word(junk);
		wait_busy(1'b0, "dropped command test");
		send_cmd(OP_XFER, w, '0);
		wait_busy(1'b1, "dropped command test");
		repeat (3) @(negedge CLK50MHZ);
		cmd_valid = 1'b1;
		cmd_op    = OP_POLL;
		cmd_data  = junk;
		cmd_mask  = '1;
		@(negedge CLK50MHZ);
		cmd_valid = 1'b0;
		wait_rsp("XFER with dropped command");
		repeat (200) @(negedge CLK50MHZ);

		next_word(w);
		run_cmd(OP_XFER, w, '0, "final XFER");
		repeat (20) @(negedge CLK50MHZ);

		$display("Errors: assertion %0d, slave %0d, timeout %0d",
			assert_errs, rx_errors, timeout_errs);
		if (assert_errs == 0 && rx_errors == 0 && timeout_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
